// ==== filelist.f ====
rtl/commit_pkg.sv
rtl/exception_checker.sv
rtl/mem_access.sv
rtl/commit_output.sv
rtl/commit.sv
testbench/clock_gen.sv
testbench/commit_assertions.sv
testbench/tb_commit.sv

// ==== rtl/commit.sv ====
`timescale 1ns/100ps

module commit import commit_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  exec_data_t [1:0] in,
    input  logic             first_cycle_c,
    output logic             dmem_en,
    output logic             dmem_wt,
    output logic [1:0]       dmem_size,
    output word_t            dmem_addr,
    output word_t            dmem_wd,
    input  word_t            dmem_rd,
    input  logic             dmem_data_ok,
    input  logic [5:0]       ext_int,
    input  logic             timer_interrupt,
    output exec_data_t [1:0] out,
    output logic             finish_c,
    output logic             pc_m_c,
    output pc_data_t         fetch,
    output bypass_upd_t      bypass,
    output logic             exception_valid,
    output exception_t       exception_data,
    output logic             is_eret,
    output word_t            pc_commit_c,
    output logic             predict_wen,
    output bpb_result_t      destpc_commit_c
);

    exec_data_t [1:0] chk;
    logic [1:0]       exc_valid;
    word_t            pc_exc;
    exception_t [1:0] exc_data;
    logic             slot0_squash;
    word_t            mem_rd;
    logic             mem_slot;

    // slot 0 dies behind a fault or eret in slot 1
    assign slot0_squash = exc_valid[1] | (in[1].valid & (in[1].op == ERET));

    exception_checker exc_chk1 (
        .rst(rst),
        .squash(1'b0),
        .slot(in[1]),
        .ext_int(ext_int),
        .timer_interrupt(timer_interrupt),
        .exc_valid(exc_valid[1]),
        .pc_exception(pc_exc),
        .exc_data(exc_data[1]),
        .slot_out(chk[1])
    );

    // interrupts are only taken on the older slot
    exception_checker exc_chk0 (
        .rst(rst),
        .squash(slot0_squash),
        .slot(in[0]),
        .ext_int(6'd0),
        .timer_interrupt(1'b0),
        .exc_valid(exc_valid[0]),
        .pc_exception(),
        .exc_data(exc_data[0]),
        .slot_out(chk[0])
    );

    assign exception_valid = exc_valid[1] | exc_valid[0];
    assign exception_data  = exc_valid[1] ? exc_data[1] : exc_data[0];

    mem_access u_mem_access (
        .rst(rst),
        .slots(chk),
        .first_cycle_c(first_cycle_c),
        .dmem_en(dmem_en),
        .dmem_wt(dmem_wt),
        .dmem_size(dmem_size),
        .dmem_addr(dmem_addr),
        .dmem_wd(dmem_wd),
        .dmem_rd(dmem_rd),
        .dmem_data_ok(dmem_data_ok),
        .finish_c(finish_c),
        .mem_rd(mem_rd),
        .mem_slot(mem_slot)
    );

    commit_output u_commit_output (
        .slots(chk),
        .mem_rd(mem_rd),
        .mem_slot(mem_slot),
        .in_slot1(in[1]),
        .exc_valid(exception_valid),
        .pc_exception(pc_exc),
        .out(out),
        .bypass(bypass),
        .fetch(fetch),
        .pc_m_c(pc_m_c),
        .is_eret(is_eret),
        .pc_commit_c(pc_commit_c),
        .predict_wen(predict_wen),
        .destpc_commit_c(destpc_commit_c)
    );

endmodule

// ==== rtl/commit_output.sv ====
`timescale 1ns/100ps

module commit_output import commit_pkg::*; (
    input  exec_data_t [1:0] slots,
    input  word_t            mem_rd,
    input  logic             mem_slot,
    input  exec_data_t       in_slot1,
    input  logic             exc_valid,
    input  word_t            pc_exception,
    output exec_data_t [1:0] out,
    output bypass_upd_t      bypass,
    output pc_data_t         fetch,
    output logic             pc_m_c,
    output logic             is_eret,
    output word_t            pc_commit_c,
    output logic             predict_wen,
    output bpb_result_t      destpc_commit_c
);

    logic s1_eret;
    logic s0_eret;
    logic s1_branch;
    logic s1_jump;
    logic s1_jr;

    // load data lands in the slot that owns the access
    always_comb begin
        out = slots;
        for (int i = 0; i < 2; i++) begin
            if (slots[i].memtoreg && (mem_slot == i[0])) begin
                out[i].result = mem_rd;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            bypass.destreg[i]  = out[i].destreg;
            bypass.result[i]   = out[i].result;
            bypass.wen[i]      = out[i].regwrite;
            bypass.memtoreg[i] = out[i].memtoreg;
        end
    end

    assign s1_eret   = slots[1].valid & (slots[1].op == ERET);
    assign s0_eret   = slots[0].valid & (slots[0].op == ERET);
    assign s1_branch = slots[1].valid & slots[1].branch;
    assign s1_jump   = slots[1].valid & slots[1].jump;
    assign s1_jr     = slots[1].valid & slots[1].jr;

    assign is_eret = s1_eret | s0_eret;

    always_comb begin
        fetch.exception_valid = exc_valid;
        fetch.is_eret         = is_eret;
        fetch.pcexception     = pc_exception;
        fetch.epc             = s1_eret ? slots[1].epc : slots[0].epc;
        // only a mispredict needs a new fetch pc
        fetch.branch          = s1_branch & (slots[1].taken != slots[1].pred_taken);
        fetch.jump            = s1_jump & ~slots[1].pred_taken;
        fetch.jr              = s1_jr;
        // predicted taken but fell through, so resume after the delay slot
        fetch.pcbranch        = slots[1].pred_taken ? (slots[0].pc + 32'd4) : slots[1].pcbranch;
        fetch.pcjr            = slots[1].srca;
        fetch.pcjump          = slots[1].pcjump;
    end

    assign pc_m_c = fetch.branch | fetch.jump | fetch.jr;

    assign pc_commit_c = slots[1].pc;
    assign predict_wen = s1_branch | (s1_jump & ~slots[1].jr);

    always_comb begin
        destpc_commit_c.taken  = slots[1].taken | (slots[1].jump & ~in_slot1.jr);
        destpc_commit_c.target = slots[1].jump ? slots[1].pcjump : slots[1].pcbranch;
    end

endmodule

// ==== rtl/commit_pkg.sv ====
package commit_pkg;

    typedef logic [31:0] word_t;

    // entry point for all exceptions and interrupts
    localparam word_t exc_vector = 32'hBFC00380;

    // dmem_size encoding
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    typedef enum logic [4:0] {
        ALU,
        LW,
        LH,
        LHU,
        LB,
        LBU,
        SW,
        SH,
        SB,
        BRANCH,
        J,
        JAL,
        JR,
        ERET,
        SYSCALL,
        BREAK,
        RESERVED
    } decoded_op_t;

    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_t;

    typedef struct packed {
        logic        valid;
        decoded_op_t op;
        word_t       pc;
        word_t       result;
        word_t       srca;
        word_t       store_data;
        word_t       addr;
        logic [4:0]  destreg;
        logic        regwrite;
        logic        memtoreg;
        logic        memwrite;
        logic        branch;
        logic        jump;
        logic        jr;
        logic        taken;
        logic        pred_taken;
        word_t       pcbranch;
        word_t       pcjump;
        word_t       epc;
        logic        ovf;
    } exec_data_t;

    typedef struct packed {
        exc_code_t code;
        word_t     bad_vaddr;
        word_t     pc;
    } exception_t;

    typedef struct packed {
        logic        en;
        logic        wt;
        logic [1:0]  size;
        word_t       addr;
        word_t       wd;
        decoded_op_t op;
    } mem_req_t;

    // index 1 is the older slot
    typedef struct packed {
        logic [1:0][4:0] destreg;
        word_t [1:0]     result;
        logic [1:0]      wen;
        logic [1:0]      memtoreg;
    } bypass_upd_t;

    typedef struct packed {
        logic  exception_valid;
        logic  is_eret;
        word_t pcexception;
        word_t epc;
        logic  branch;
        logic  jump;
        logic  jr;
        word_t pcbranch;
        word_t pcjr;
        word_t pcjump;
    } pc_data_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } bpb_result_t;

    function automatic logic [1:0] access_size(decoded_op_t op);
        case (op)
            LW, SW:      return size_word;
            LH, LHU, SH: return size_half;
            default:     return size_byte;
        endcase
    endfunction

    function automatic logic misaligned(logic [1:0] size, word_t addr);
        return ((size == size_half) && addr[0]) ||
               ((size == size_word) && (addr[1:0] != 2'b00));
    endfunction

endpackage

// ==== rtl/exception_checker.sv ====
`timescale 1ns/100ps

module exception_checker import commit_pkg::*; (
    input  logic       rst,
    input  logic       squash,
    input  exec_data_t slot,
    input  logic [5:0] ext_int,
    input  logic       timer_interrupt,
    output logic       exc_valid,
    output word_t      pc_exception,
    output exception_t exc_data,
    output exec_data_t slot_out
);

    logic live;
    logic interrupt;
    logic bad_align;

    assign live      = slot.valid & ~rst & ~squash;
    assign interrupt = (|ext_int) | timer_interrupt;
    assign bad_align = misaligned(access_size(slot.op), slot.addr);

    // priority chain, highest first
    always_comb begin
        exc_valid          = 1'b0;
        exc_data.code      = INT;
        exc_data.bad_vaddr = '0;
        exc_data.pc        = slot.pc;
        if (live) begin
            exc_valid = 1'b1;
            if (interrupt) begin
                exc_data.code = INT;
            end else if (slot.memtoreg && bad_align) begin
                exc_data.code      = ADEL;
                exc_data.bad_vaddr = slot.addr;
            end else if (slot.memwrite && bad_align) begin
                exc_data.code      = ADES;
                exc_data.bad_vaddr = slot.addr;
            end else if (slot.op == SYSCALL) begin
                exc_data.code = SYS;
            end else if (slot.op == BREAK) begin
                exc_data.code = BP;
            end else if (slot.op == RESERVED) begin
                exc_data.code = RI;
            end else if (slot.ovf) begin
                exc_data.code = OV;
            end else begin
                exc_valid = 1'b0;
            end
        end
    end

    assign pc_exception = exc_vector;

    // strip side effects of a dead or faulting slot
    always_comb begin
        slot_out = slot;
        if (rst || squash) begin
            slot_out.valid    = 1'b0;
            slot_out.regwrite = 1'b0;
            slot_out.memwrite = 1'b0;
            slot_out.memtoreg = 1'b0;
        end else if (exc_valid) begin
            slot_out.regwrite = 1'b0;
            slot_out.memwrite = 1'b0;
            slot_out.memtoreg = 1'b0;
        end
    end

endmodule

// ==== rtl/mem_access.sv ====
`timescale 1ns/100ps

module mem_access import commit_pkg::*; (
    input  logic              rst,
    input  exec_data_t [1:0]  slots,
    input  logic              first_cycle_c,
    output logic              dmem_en,
    output logic              dmem_wt,
    output logic [1:0]        dmem_size,
    output word_t             dmem_addr,
    output word_t             dmem_wd,
    input  word_t             dmem_rd,
    input  logic              dmem_data_ok,
    output logic              finish_c,
    output word_t             mem_rd,
    output logic              mem_slot
);

    mem_req_t   req;
    exec_data_t sel;
    logic       slot1_mem;
    logic [7:0] rd_byte;
    logic [15:0] rd_half;

    // older slot wins if both carry an access
    assign slot1_mem = slots[1].valid & (slots[1].memtoreg | slots[1].memwrite);
    assign mem_slot  = slot1_mem;
    assign sel       = slot1_mem ? slots[1] : slots[0];

    always_comb begin
        req.en   = ~rst & sel.valid & (sel.memtoreg | sel.memwrite);
        req.wt   = sel.memwrite;
        req.size = access_size(sel.op);
        req.addr = sel.addr;
        req.op   = sel.op;
        case (req.size)
            size_byte: req.wd = {4{sel.store_data[7:0]}};
            size_half: req.wd = {2{sel.store_data[15:0]}};
            default:   req.wd = sel.store_data;
        endcase
    end

    assign dmem_en   = req.en;
    assign dmem_wt   = req.wt;
    assign dmem_size = req.size;
    assign dmem_addr = req.addr;
    assign dmem_wd   = req.wd;

    // lane select for sub-word loads
    always_comb begin
        case (req.addr[1:0])
            2'd0:    rd_byte = dmem_rd[7:0];
            2'd1:    rd_byte = dmem_rd[15:8];
            2'd2:    rd_byte = dmem_rd[23:16];
            default: rd_byte = dmem_rd[31:24];
        endcase
        rd_half = req.addr[1] ? dmem_rd[31:16] : dmem_rd[15:0];
    end

    always_comb begin
        case (req.op)
            LB:      mem_rd = {{24{rd_byte[7]}}, rd_byte};
            LBU:     mem_rd = {24'd0, rd_byte};
            LH:      mem_rd = {{16{rd_half[15]}}, rd_half};
            LHU:     mem_rd = {16'd0, rd_half};
            default: mem_rd = dmem_rd;
        endcase
    end

    // first cycle of a pair never completes an access
    assign finish_c = first_cycle_c ? ~req.en : (~req.en | dmem_data_ok);

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== testbench/commit_assertions.sv ====
`timescale 1ns/100ps

module commit_assertions (
    input logic        clk,
    input logic        rst,
    input logic        dmem_en,
    input logic [1:0]  dmem_size,
    input logic [31:0] dmem_addr,
    input logic        first_cycle_c,
    input logic        finish_c,
    input logic        dmem_data_ok,
    input logic        slot1_exc,
    input logic        slot0_wen
);

    // legal size with an address aligned to it
    size_valid: assert property (@(posedge clk) disable iff (rst)
        dmem_en |-> ((dmem_size != 2'd3) &&
                     !((dmem_size == 2'd1) && dmem_addr[0]) &&
                     !((dmem_size == 2'd2) && (dmem_addr[1:0] != 2'b00))))
        else $error("dmem request has a bad size or a misaligned address");

    squash_wb: assert property (@(posedge clk) disable iff (rst)
        slot1_exc |-> !slot0_wen)
        else $error("slot 0 still writes back behind a slot 1 fault");

    finish_follows_ok: assert property (@(posedge clk) disable iff (rst)
        (dmem_en && !first_cycle_c) |-> (finish_c == dmem_data_ok))
        else $error("finish_c does not follow dmem_data_ok");

endmodule

// ==== testbench/commit_testdata.txt ====
// op1 op0 addr1 addr0 store_data rd_word ctrl expected
// ctrl: [5:0] ext_int, [8] timer, [12] taken, [16] pred_taken, [20] ovf1, [24] ovf0
00000006 00000000 00000100 00000000 1234A5C6 80F17F02 00000000 1234A5C6
00000007 00000000 00000102 00000000 1234A5C6 80F17F02 00000000 A5C6A5C6
00000000 00000008 00000000 00000103 1234A5C6 80F17F02 00000000 C6C6C6C6
00000001 00000000 00000104 00000000 1234A5C6 80F17F02 00000000 80F17F02
00000002 00000000 00000106 00000000 1234A5C6 80F17F02 00000000 FFFF80F1
00000003 00000000 00000104 00000000 1234A5C6 80F17F02 00000000 00007F02
00000000 00000004 00000000 00000101 1234A5C6 80F17F02 00000000 0000007F
00000004 00000000 00000103 00000000 1234A5C6 80F17F02 00000000 FFFFFF80
00000005 00000000 00000102 00000000 1234A5C6 80F17F02 00000000 000000F1
00000001 00000006 00000102 00000200 1234A5C6 80F17F02 00000000 00000004
00000007 00000000 00000101 00000000 1234A5C6 80F17F02 00000000 00000005
00000000 00000001 00000000 00000200 1234A5C6 80F17F02 00100000 0000000C
0000000E 00000000 00000000 00000000 1234A5C6 80F17F02 00000000 00000008
00000000 0000000F 00000000 00000000 1234A5C6 80F17F02 00000000 00000009
00000010 00000000 00000000 00000000 1234A5C6 80F17F02 00000000 0000000A
00000000 00000000 00000000 00000000 1234A5C6 80F17F02 00000004 00000000
00000001 00000000 00000102 00000000 1234A5C6 80F17F02 00000100 00000000
0000000D 00000000 00000000 00000000 1234A5C6 80F17F02 00000000 00005000
00000009 00000000 00000000 00000000 1234A5C6 80F17F02 00001000 00003000
00000009 00000000 00000000 00000000 1234A5C6 80F17F02 00010000 00001008
00000009 00000000 00000000 00000000 1234A5C6 80F17F02 00011000 00000000
0000000A 00000000 00000000 00000000 1234A5C6 80F17F02 00000000 00004000
0000000B 00000000 00000000 00000000 1234A5C6 80F17F02 00010000 00000000
0000000C 00000000 00000000 00000000 1234A5C6 80F17F02 00000000 00002000
00000000 00000000 00000000 00000000 1234A5C6 80F17F02 00000000 00000000
00000009 00000006 00000000 00000208 1234A5C6 80F17F02 00001000 1234A5C6

// ==== testbench/tb_commit.sv ====
`timescale 1ns/100ps

module tb_commit import commit_pkg::*; ();

    logic             clk;
    logic             rst;
    exec_data_t [1:0] in;
    logic             first_cycle_c;
    logic             dmem_en;
    logic             dmem_wt;
    logic [1:0]       dmem_size;
    word_t            dmem_addr;
    word_t            dmem_wd;
    word_t            dmem_rd;
    logic             dmem_data_ok;
    logic [5:0]       ext_int;
    logic             timer_interrupt;
    exec_data_t [1:0] out;
    logic             finish_c;
    logic             pc_m_c;
    pc_data_t         fetch;
    bypass_upd_t      bypass;
    logic             exception_valid;
    exception_t       exception_data;
    logic             is_eret;
    word_t            pc_commit_c;
    logic             predict_wen;
    bpb_result_t      destpc_commit_c;

    word_t tdata [0:255];
    int    seed = 93;
    int    errors = 0;
    int    test_errors;
    int    passed = 0;
    int    failed = 0;
    int    ntests = 0;
    bit    timed_out = 1'b0;

    clock_gen clk_gen0 (.clk(clk), .rst(rst));

    commit dut0 (.*);

    bind commit commit_assertions asrt0 (
        .clk(clk),
        .rst(rst),
        .dmem_en(dmem_en),
        .dmem_size(dmem_size),
        .dmem_addr(dmem_addr),
        .first_cycle_c(first_cycle_c),
        .finish_c(finish_c),
        .dmem_data_ok(dmem_data_ok),
        .slot1_exc(exc_valid[1]),
        .slot0_wen(out[0].regwrite)
    );

    task automatic expect_true(input logic ok, input string what);
        assert (ok === 1'b1) else begin
            $display("CHECK FAILED at %0t: %s", $time, what);
            errors++;
            test_errors++;
        end
    endtask

    function automatic logic is_load(decoded_op_t op);
        return op inside {LW, LH, LHU, LB, LBU};
    endfunction

    function automatic logic is_store(decoded_op_t op);
        return op inside {SW, SH, SB};
    endfunction

    function automatic logic [1:0] width_code(decoded_op_t op);
        if (op == LW || op == SW)
            return 2'd2;
        if (op == LH || op == LHU || op == SH)
            return 2'd1;
        return 2'd0;
    endfunction

    // {valid, cause}
    function automatic logic [5:0] fault_of(decoded_op_t op, word_t addr, logic ovf, logic irq);
        logic bad;
        bad = (width_code(op) == 2'd1 && addr[0]) || (width_code(op) == 2'd2 && addr[1:0] != 0);
        if (irq)
            return 6'h20;
        if (is_load(op) && bad)
            return 6'h24;
        if (is_store(op) && bad)
            return 6'h25;
        if (op == SYSCALL)
            return 6'h28;
        if (op == BREAK)
            return 6'h29;
        if (op == RESERVED)
            return 6'h2a;
        if (ovf)
            return 6'h2c;
        return 6'h00;
    endfunction

    function automatic word_t load_lane(decoded_op_t op, word_t addr, word_t rd);
        logic [7:0]  b;
        logic [15:0] h;
        b = rd >> (8 * addr[1:0]);
        h = addr[1] ? rd[31:16] : rd[15:0];
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'd0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'd0, h};
            default: return rd;
        endcase
    endfunction

    function automatic exec_data_t build_slot(decoded_op_t op, word_t pc, word_t addr,
                                              word_t sdata, logic [4:0] dreg, logic taken,
                                              logic pred, logic ovf);
        exec_data_t s;
        s = '0;
        s.valid      = 1'b1;
        s.op         = op;
        s.pc         = pc;
        s.result     = pc ^ 32'h5A5A0000;
        s.srca       = pc + 32'h1000;
        s.store_data = sdata;
        s.addr       = addr;
        s.destreg    = dreg;
        s.regwrite   = (op == ALU) || is_load(op) || (op == JAL);
        s.memtoreg   = is_load(op);
        s.memwrite   = is_store(op);
        s.branch     = (op == BRANCH);
        s.jump       = (op == J) || (op == JAL);
        s.jr         = (op == JR);
        s.taken      = taken;
        s.pred_taken = pred;
        // targets differ per slot so a wrong slot select shows
        s.pcbranch   = pc + 32'h2000;
        s.pcjump     = pc + 32'h3000;
        s.epc        = pc + 32'h4000;
        s.ovf        = ovf;
        return s;
    endfunction

    task automatic run_test(input int t);
        decoded_op_t op1, op0;
        word_t       a1, a0, sd, rd, ctrl, key, obs, wd_exp, tgt, ld_exp;
        logic [5:0]  f1, f0;
        logic        sq0, m1, m0, en, ld, mslot, wb1, wb0, irq;
        logic        br, jp, jr, eret0;
        int          delay, cycles;
        op1  = decoded_op_t'(tdata[8*t][4:0]);
        op0  = decoded_op_t'(tdata[8*t+1][4:0]);
        a1   = tdata[8*t+2];
        a0   = tdata[8*t+3];
        sd   = tdata[8*t+4];
        rd   = tdata[8*t+5];
        ctrl = tdata[8*t+6];
        key  = tdata[8*t+7];
        test_errors = 0;
        @(negedge clk);
        in[1] = build_slot(op1, 32'h1000, a1, sd, 5'd5, ctrl[12], ctrl[16], ctrl[20]);
        in[0] = build_slot(op0, 32'h1004, a0, sd, 5'd6, 1'b0, 1'b0, ctrl[24]);
        ext_int         = ctrl[5:0];
        timer_interrupt = ctrl[8];
        dmem_rd         = rd;
        first_cycle_c   = 1'b1;
        delay           = $unsigned($random(seed)) % 4;
        dmem_data_ok    = (delay == 0);
        #1;

        irq   = (ctrl[5:0] != 0) || ctrl[8];
        f1    = fault_of(op1, a1, ctrl[20], irq);
        sq0   = f1[5] || (op1 == ERET);
        f0    = sq0 ? 6'h00 : fault_of(op0, a0, ctrl[24], 1'b0);
        m1    = (is_load(op1) || is_store(op1)) && !f1[5];
        m0    = (is_load(op0) || is_store(op0)) && !f0[5] && !sq0;
        en    = m1 || m0;
        mslot = m1;
        ld    = mslot ? is_load(op1) : is_load(op0);
        wd_exp = sd;
        if (width_code(mslot ? op1 : op0) == 2'd0)
            wd_exp = {4{sd[7:0]}};
        else if (width_code(mslot ? op1 : op0) == 2'd1)
            wd_exp = {2{sd[15:0]}};
        wb1   = in[1].regwrite && !f1[5];
        wb0   = in[0].regwrite && !f0[5] && !sq0;
        br    = (op1 == BRANCH) && (ctrl[12] != ctrl[16]);
        jp    = (op1 == J || op1 == JAL) && !ctrl[16];
        jr    = (op1 == JR);
        eret0 = (op0 == ERET) && !sq0;
        tgt   = jr ? 32'h2000 : jp ? 32'h4000 : (ctrl[16] ? 32'h1008 : 32'h3000);

        expect_true(exception_valid == (f1[5] || f0[5]), "exception_valid");
        if (f1[5] || f0[5]) begin
            expect_true(exception_data.code == (f1[5] ? f1[4:0] : f0[4:0]), "exception code");
            expect_true(exception_data.pc == (f1[5] ? 32'h1000 : 32'h1004), "exception pc");
            expect_true(fetch.pcexception == exc_vector, "pcexception");
        end
        if (f1[5] && (f1[4:0] == 5'd4 || f1[4:0] == 5'd5))
            expect_true(exception_data.bad_vaddr == a1, "bad_vaddr");
        expect_true(fetch.exception_valid == (f1[5] || f0[5]) &&
                    fetch.is_eret == ((op1 == ERET) || eret0), "fetch exception and eret flags");
        expect_true(dmem_en == en, "dmem_en");
        if (en) begin
            expect_true(dmem_wt == !ld, "dmem_wt");
            expect_true(dmem_size == width_code(mslot ? op1 : op0), "dmem_size");
            expect_true(dmem_addr == (mslot ? a1 : a0), "dmem_addr");
            if (!ld)
                expect_true(dmem_wd == wd_exp, "dmem_wd lanes");
        end
        expect_true(out[1].regwrite == wb1 && out[0].regwrite == wb0, "out regwrite");
        expect_true(out[0].valid == !sq0, "slot 0 valid");
        expect_true(out[0].memwrite == (is_store(op0) && m0), "slot 0 memwrite");
        expect_true(bypass.wen == {wb1, wb0}, "bypass wen");
        expect_true(bypass.destreg[1] == 5'd5 && bypass.destreg[0] == 5'd6, "bypass destreg");
        expect_true(bypass.memtoreg == {is_load(op1) && m1, is_load(op0) && m0},
                    "bypass memtoreg");
        if (en && ld) begin
            ld_exp = load_lane(mslot ? op1 : op0, mslot ? a1 : a0, rd);
            obs = mslot ? out[1].result : out[0].result;
            expect_true(obs == ld_exp, "load result");
            expect_true(bypass.result[mslot] == ld_exp, "bypass result");
        end
        expect_true(is_eret == ((op1 == ERET) || eret0), "is_eret");
        if ((op1 == ERET) || eret0)
            expect_true(fetch.epc == (op1 == ERET ? 32'h5000 : 32'h5004), "epc");
        expect_true(fetch.branch == br && fetch.jump == jp && fetch.jr == jr, "redirect flags");
        expect_true(pc_m_c == (br || jp || jr), "pc_m_c");
        if (br || jp || jr)
            expect_true((jr ? fetch.pcjr : jp ? fetch.pcjump : fetch.pcbranch) == tgt,
                        "redirect target");
        expect_true(predict_wen == (op1 == BRANCH || op1 == J || op1 == JAL), "predict_wen");
        expect_true(pc_commit_c == 32'h1000, "pc_commit_c");
        if (op1 == BRANCH || op1 == J || op1 == JAL) begin
            expect_true(destpc_commit_c.taken == (ctrl[12] || op1 != BRANCH), "bpb taken");
            expect_true(destpc_commit_c.target == (op1 == BRANCH ? 32'h3000 : 32'h4000),
                        "bpb target");
        end

        // key column from the data file
        if (exception_valid)
            obs = exception_data.code;
        else if (dmem_en)
            obs = dmem_wt ? dmem_wd : (out[1].memtoreg ? out[1].result : out[0].result);
        else if (pc_m_c)
            obs = fetch.jr ? fetch.pcjr : (fetch.jump ? fetch.pcjump : fetch.pcbranch);
        else if (is_eret)
            obs = fetch.epc;
        else
            obs = 32'h0;
        expect_true(obs == key, $sformatf("key value %h, expected %h", obs, key));

        expect_true(finish_c == !en, "finish_c in first cycle");
        cycles = 0;
        while (!finish_c && cycles < 20) begin
            @(negedge clk);
            first_cycle_c = 1'b0;
            cycles++;
            if (cycles >= delay)
                dmem_data_ok = 1'b1;
            #1;
            expect_true(dmem_en == en, "request held during wait");
            expect_true(finish_c == (!en || cycles >= delay), "finish_c during wait");
        end
        if (!finish_c) begin
            $display("timeout: finish_c never rose in test %0d", t);
            timed_out = 1'b1;
            failed++;
        end else begin
            dmem_data_ok = 1'b0;
            if (test_errors == 0)
                passed++;
            else
                failed++;
            $display("test %0d op1=%s op0=%s: %s", t, op1.name(), op0.name(),
                     test_errors == 0 ? "ok" : "errors");
        end
    endtask

    initial begin
        int guard;
        for (int i = 0; i < 256; i++)
            tdata[i] = 'x;
        $readmemh("testbench/commit_testdata.txt", tdata);

        // inputs that must be ignored while reset is held
        in[1] = build_slot(BRANCH, 32'h1000, 32'h0, 32'h0, 5'd5, 1'b1, 1'b0, 1'b0);
        in[0] = build_slot(LW, 32'h1004, 32'h100, 32'h0, 5'd6, 1'b0, 1'b0, 1'b0);
        first_cycle_c   = 1'b1;
        dmem_rd         = '0;
        dmem_data_ok    = 1'b0;
        ext_int         = 6'd0;
        timer_interrupt = 1'b0;
        @(negedge clk);
        #1;
        test_errors = 0;
        expect_true(!dmem_en && !exception_valid && !predict_wen && !pc_m_c, "outputs in reset");

        guard = 0;
        while (rst && guard < 20) begin
            @(negedge clk);
            guard++;
        end
        if (rst) begin
            $display("timeout: reset never released");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            while (ntests < 32 && tdata[8*ntests] !== 'x && !timed_out) begin
                run_test(ntests);
                ntests++;
            end
            $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                     ntests, passed, failed, errors);
            if (errors == 0 && !timed_out && ntests > 0)
                $display("STATUS: PASS");
            else
                $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule
